/* verilog/fd1094_pkg.sv */
// widths, 68000 opcode constants and state change command codes
// shared vector types for the decryption subsystem
package fd1094_pkg;

    // bus and table sizes
    localparam int ADR_W  = 23;  // cpu word address, bits 23:1
    localparam int DAT_W  = 16;  // program word
    localparam int KEY_AW = 8;   // 256 entry key table
    localparam int KEY_W  = 8;   // key byte
    localparam int ST_W   = 8;   // state byte

    // opcodes watched in the decrypted stream
    localparam logic [7:0]       OP_CMPI_HI = 8'h0c;    // cmpi, size in bits 7:6
    localparam logic [DAT_W-1:0] OP_RTE     = 16'h4e73;
    localparam logic [DAT_W-1:0] CMD_END    = 16'hffff; // second extension word

    // command field, bits 9:8 of the first extension word
    localparam logic [1:0] CMD_SET     = 2'd0;  // load state from bits 7:0
    localparam logic [1:0] CMD_RESET   = 2'd1;  // state 0, leave irq mode
    localparam logic [1:0] CMD_IRQ_ON  = 2'd2;
    localparam logic [1:0] CMD_IRQ_OFF = 2'd3;

    // word address keeps the 68000 bit numbering
    typedef logic [ADR_W:1]    adr_t;
    typedef logic [DAT_W-1:0]  dat_t;
    typedef logic [KEY_W-1:0]  key_t;
    typedef logic [ST_W-1:0]   st_t;

endpackage

/* verilog/fd1094_fetch.sv */
// access sequencer: cpu wishbone slave in, rom wishbone master out
// one outstanding read, ack returned once the word is decrypted
module fd1094_fetch
    import fd1094_pkg::*;
(
    input  logic clk,
    input  logic rst,

    // cpu side, classic slave
    input  logic cpu_cyc,
    input  logic cpu_stb,
    input  adr_t cpu_adr,
    input  logic cpu_op,     // high on opcode fetch
    output logic cpu_ack,

    // rom side, classic master
    output logic rom_cyc,
    output logic rom_stb,
    output adr_t rom_adr,
    input  dat_t rom_dat,
    input  logic rom_ack,

    // towards the decrypt pipe
    output dat_t rom_word,
    output adr_t fetch_adr,
    output logic fetch_op,
    output logic word_vld,
    input  logic dec_vld     // decrypted word ready
);

    typedef enum logic [1:0] {
        S_IDLE,  // waiting for a cpu request
        S_ROM,   // rom read in flight
        S_DEC    // word in the decrypt pipe
    } phase_t;

    phase_t phase;
    adr_t   adr_q;   // request address, held for the whole access
    logic   op_q;    // opcode flag of the request
    logic   req;
    logic   accept;

    assign req    = cpu_cyc && cpu_stb;
    assign accept = (phase == S_IDLE) && req; // new requests only when idle

    // phase sequencer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase   <= S_IDLE;
            rom_cyc <= 1'b0;
            rom_stb <= 1'b0;
        end else begin
            case (phase)
                S_IDLE: begin
                    if (req) begin
                        phase   <= S_ROM;
                        rom_cyc <= 1'b1;  // strobe the cycle after accept
                        rom_stb <= 1'b1;
                    end
                end
                S_ROM: begin
                    if (rom_ack) begin   // rom may stall any length
                        phase   <= S_DEC;
                        rom_cyc <= 1'b0;
                        rom_stb <= 1'b0;
                    end
                end
                S_DEC: begin
                    if (dec_vld)
                        phase <= S_IDLE; // ack goes out this cycle
                end
                default: begin
                    phase   <= S_IDLE;
                    rom_cyc <= 1'b0;
                    rom_stb <= 1'b0;
                end
            endcase
        end
    end

    // request latch, payload only
    always_ff @(posedge clk) begin
        if (accept) begin
            adr_q <= cpu_adr;
            op_q  <= cpu_op;
        end
    end

    assign rom_adr   = adr_q;
    assign fetch_adr = adr_q;  // same address feeds the key index
    assign fetch_op  = op_q;

    // rom data goes straight into the decrypt input register
    assign rom_word = rom_dat;
    assign word_vld = (phase == S_ROM) && rom_ack;

    // single cycle ack, lines up with dec_vld
    assign cpu_ack = (phase == S_DEC) && dec_vld;

endmodule

/* verilog/fd1094_key_ram.sv */
// key table, 256 bytes: write port, registered read port
// plus a mirror of entry 0 used as the global key
module fd1094_key_ram
    import fd1094_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // load port, one write per cycle
    input  logic              key_we,
    input  logic [KEY_AW-1:0] key_adr,
    input  key_t              key_dat,

    // lookup from the decrypt pipe
    input  logic [KEY_AW-1:0] key_rd_adr,
    output key_t              key_rd_dat,   // one cycle after the address

    output key_t              gkey          // entry 0
);

    key_t mem [0:(1 << KEY_AW)-1];  // contents undefined until loaded

    // write side
    always_ff @(posedge clk) begin
        if (key_we)
            mem[key_adr] <= key_dat;
    end

    // registered read, old data on a same cycle write
    always_ff @(posedge clk) begin
        key_rd_dat <= mem[key_rd_adr];
    end

    // global key copy
    // separate register so irq mode sees it without a read slot
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gkey <= '0;
        end else if (key_we && key_adr == '0) begin
            gkey <= key_dat;  // follow writes to entry 0
        end
    end

endmodule

/* verilog/fd1094_decrypt.sv */
// key index selection and two stage word decryption
// stage 1 runs next to the key read, stage 2 applies the key
module fd1094_decrypt
    import fd1094_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // from fetch
    input  dat_t              rom_word,
    input  adr_t              fetch_adr,
    input  logic              fetch_op,
    input  logic              word_vld,

    input  st_t               st,           // current state from ctrl

    // key table lookup
    output logic [KEY_AW-1:0] key_rd_adr,
    input  key_t              key_rd_dat,

    // decrypted word out
    output dat_t              dec_word,
    output adr_t              dec_adr,
    output logic              dec_op,
    output logic              dec_vld
);

    // stage 1 registers
    dat_t word_q;
    adr_t adr_q;
    logic op_q;
    st_t  st_q;   // state as seen at word_vld
    logic vld_q;

    key_t k_lo;   // low byte mask

    // opcode fetches index by address xor state, data by address only
    assign key_rd_adr = fetch_op ? (fetch_adr[KEY_AW:1] ^ st) : fetch_adr[KEY_AW:1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_q   <= 1'b0;
            dec_vld <= 1'b0;
        end else begin
            vld_q   <= word_vld;
            dec_vld <= vld_q;  // two cycles after word_vld
        end
    end

    // carry word and metadata while the key byte is read
    always_ff @(posedge clk) begin
        if (word_vld) begin
            word_q <= rom_word;
            adr_q  <= fetch_adr;
            op_q   <= fetch_op;
            st_q   <= st;
        end
    end

    assign k_lo = op_q ? (key_rd_dat ^ st_q) : key_rd_dat;

    // output register
    always_ff @(posedge clk) begin
        if (vld_q) begin
            dec_word <= word_q ^ {key_rd_dat, k_lo};
            dec_adr  <= adr_q;
            dec_op   <= op_q;
        end
    end

endmodule

/* verilog/fd1094_ctrl.sv */
// state byte and interrupt mode control
// tracks cmpi.l state change commands, rte and irq acknowledge
module fd1094_ctrl
    import fd1094_pkg::*;
(
    input  logic clk,
    input  logic rst,

    // decrypted stream
    input  dat_t dec_word,
    input  adr_t dec_adr,
    input  logic dec_op,
    input  logic dec_vld,

    input  logic irq_ack,  // one cycle pulse
    input  key_t gkey,     // replaces the state in irq mode

    output st_t  st
);

    st_t        state;
    logic       irq_mode;
    logic [1:0] trk;      // one hot step, 0 when idle
    dat_t       cmd_q;    // first extension word
    logic [1:0] last_a;   // address bits 2:1 of the last access

    logic adr_chg;
    logic step;
    logic is_cmpi;
    logic is_rte;
    logic op_idle;

    assign adr_chg = dec_adr[2:1] != last_a;
    assign step    = dec_vld && adr_chg && trk != 2'b00;
    // cmpi.l #imm only, size field 2'b10
    assign is_cmpi = dec_word[15:8] == OP_CMPI_HI && dec_word[7:6] == 2'b10;
    assign is_rte  = dec_word == OP_RTE;
    assign op_idle = dec_vld && dec_op && trk == 2'b00;

    assign st = irq_mode ? gkey : state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= '0;
            irq_mode <= 1'b0;
            trk      <= 2'b00;
            last_a   <= 2'b00;
        end else begin
            if (dec_vld)
                last_a <= dec_adr[2:1];
            if (op_idle) begin
                if (is_cmpi)
                    trk <= 2'b01;     // arm, extension words follow
                if (is_rte)
                    irq_mode <= 1'b0; // back to the state byte
            end
            if (irq_ack)
                irq_mode <= 1'b1;
            if (step) begin
                trk <= trk << 1;      // ends at 0 after the second word
                // bad end word drops the command
                if (trk[1] && dec_word == CMD_END) begin
                    case (cmd_q[9:8])
                        CMD_SET:     state <= cmd_q[ST_W-1:0];
                        CMD_RESET: begin
                            state    <= '0;
                            irq_mode <= 1'b0;
                        end
                        CMD_IRQ_ON:  irq_mode <= 1'b1;
                        CMD_IRQ_OFF: irq_mode <= 1'b0;
                        default:     state <= state;
                    endcase
                end
            end
        end
    end

    // command word latch
    always_ff @(posedge clk) begin
        if (step && trk[0])
            cmd_q <= dec_word;
    end

endmodule

/* verilog/fd1094_top.sv */
// top level of the decryption unit
// fetch sequencer, key table, decrypt pipe and state control
module fd1094_top
    import fd1094_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // cpu, wishbone classic slave
    input  logic              cpu_cyc,
    input  logic              cpu_stb,
    input  adr_t              cpu_adr,
    input  logic              cpu_op,
    output dat_t              cpu_dat,
    output logic              cpu_ack,

    // encrypted rom, wishbone classic master
    output logic              rom_cyc,
    output logic              rom_stb,
    output adr_t              rom_adr,
    input  dat_t              rom_dat,
    input  logic              rom_ack,

    // key load
    input  logic              key_we,
    input  logic [KEY_AW-1:0] key_adr,
    input  key_t              key_dat,

    input  logic              irq_ack
);

    dat_t              rom_word;
    adr_t              fetch_adr;
    logic              fetch_op;
    logic              word_vld;
    logic [KEY_AW-1:0] key_rd_adr;
    key_t              key_rd_dat;
    key_t              gkey;
    st_t               st;
    dat_t              dec_word;
    adr_t              dec_adr;
    logic              dec_op;
    logic              dec_vld;

    assign cpu_dat = dec_word;  // valid with cpu_ack

    fd1094_fetch i_fetch (
        .clk       (clk),
        .rst       (rst),
        .cpu_cyc   (cpu_cyc),
        .cpu_stb   (cpu_stb),
        .cpu_adr   (cpu_adr),
        .cpu_op    (cpu_op),
        .cpu_ack   (cpu_ack),
        .rom_cyc   (rom_cyc),
        .rom_stb   (rom_stb),
        .rom_adr   (rom_adr),
        .rom_dat   (rom_dat),
        .rom_ack   (rom_ack),
        .rom_word  (rom_word),
        .fetch_adr (fetch_adr),
        .fetch_op  (fetch_op),
        .word_vld  (word_vld),
        .dec_vld   (dec_vld)
    );

    fd1094_key_ram i_key_ram (
        .clk        (clk),
        .rst        (rst),
        .key_we     (key_we),
        .key_adr    (key_adr),
        .key_dat    (key_dat),
        .key_rd_adr (key_rd_adr),
        .key_rd_dat (key_rd_dat),
        .gkey       (gkey)
    );

    fd1094_decrypt i_decrypt (
        .clk        (clk),
        .rst        (rst),
        .rom_word   (rom_word),
        .fetch_adr  (fetch_adr),
        .fetch_op   (fetch_op),
        .word_vld   (word_vld),
        .st         (st),
        .key_rd_adr (key_rd_adr),
        .key_rd_dat (key_rd_dat),
        .dec_word   (dec_word),
        .dec_adr    (dec_adr),
        .dec_op     (dec_op),
        .dec_vld    (dec_vld)
    );

    fd1094_ctrl i_ctrl (
        .clk      (clk),
        .rst      (rst),
        .dec_word (dec_word),
        .dec_adr  (dec_adr),
        .dec_op   (dec_op),
        .dec_vld  (dec_vld),
        .irq_ack  (irq_ack),
        .gkey     (gkey),
        .st       (st)
    );

endmodule

/* testbench/tb_fd1094.sv */
// testbench for the decryption unit with clock, reset and rom responder
// reference model of key table and state control, random stimulus, watchdog
module tb_fd1094
    import fd1094_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS   = 4;
    localparam int N_DATA   = 32;   // data reads after key load
    localparam int N_OPC    = 32;   // opcodes in state 0
    localparam int N_DIR    = 100;  // directed command sequences, upper bound
    localparam int N_RAND   = 400;  // back-pressure iterations
    localparam int N_PLAN   = N_DATA + N_OPC + N_DIR + 3 * N_RAND;
    localparam int ACK_WAIT = 64;   // per access
    localparam int WD_CYCLES = N_PLAN * ACK_WAIT + 300;  // plus reset and key load

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic cpu_cyc, cpu_stb, cpu_op, cpu_ack;
    adr_t cpu_adr;
    dat_t cpu_dat;
    logic rom_cyc, rom_stb, rom_ack;
    adr_t rom_adr;
    dat_t rom_dat;
    logic key_we;
    logic [KEY_AW-1:0] key_adr;
    key_t key_dat;
    logic irq_ack;

    integer seed = 32'hdb2b_08f7;
    dat_t   rom_plan;         // encrypted word for the pending rom read
    adr_t   rom_exp_adr;      // address the pending rom read must carry
    int     n_req   = 0;
    int     ack_cnt = 0;

    // reference model
    key_t key_m [0:255];
    st_t  m_state = '0;
    logic m_irq   = 1'b0;
    int   m_trk   = 0;        // 0 idle, 1 wants command word, 2 wants end word
    dat_t m_cmd;
    logic [1:0] m_last = 2'b00;

    fd1094_top i_fd1094_top (.*);

    always #(CLK_NS / 2) clk = ~clk;

    function automatic int unsigned rnd(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic dat_t rand_opcode();
        dat_t w;
        w = dat_t'($random(seed));
        while (w[15:8] == OP_CMPI_HI || w == OP_RTE)  // keep the control path quiet
            w = dat_t'($random(seed));
        return w;
    endfunction

    function automatic st_t model_st();
        return m_irq ? key_m[0] : m_state;  // global key in irq mode
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_word(input dat_t exp, input dat_t got, input string what);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s, expected %h got %h",
                                $time, what, exp, got));
    endtask

    task automatic check_adr(input adr_t exp, input adr_t got, input string what);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s, expected %h got %h",
                                $time, what, exp, got));
    endtask

    task automatic check_ack_count(input int exp, input int got);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %0d requests but %0d cpu acks",
                                $time, exp, got));
    endtask

    // control rules fed with the intended plain words
    task automatic model_update(input adr_t a, input logic op, input dat_t w);
        if (m_trk != 0 && a[2:1] != m_last) begin
            if (m_trk == 1) begin
                m_cmd = w;
                m_trk = 2;
            end else begin
                m_trk = 0;
                if (w == 16'hffff) begin  // anything else drops the command
                    case (m_cmd[9:8])
                        2'd0: m_state = m_cmd[7:0];
                        2'd1: begin
                            m_state = '0;
                            m_irq   = 1'b0;
                        end
                        2'd2: m_irq = 1'b1;
                        default: m_irq = 1'b0;
                    endcase
                end
            end
        end else if (op && m_trk == 0) begin
            if (w[15:8] == 8'h0c && w[7:6] == 2'b10)
                m_trk = 1;                   // cmpi.l armed
            if (w == 16'h4e73)
                m_irq = 1'b0;                // rte
        end
        m_last = a[2:1];
    endtask

    // one cpu read from falling edge to falling edge
    task automatic access(input adr_t a, input logic op, input dat_t plain);
        st_t  s;
        key_t k;
        int   n;
        s = model_st();
        k = op ? key_m[a[8:1] ^ s] : key_m[a[8:1]];
        rom_plan    = op ? plain ^ {k, k ^ s} : plain ^ {k, k};
        rom_exp_adr = a;
        cpu_cyc = 1'b1;
        cpu_stb = 1'b1;
        cpu_adr = a;
        cpu_op  = op;
        n = 0;
        @(negedge clk);
        while (cpu_ack !== 1'b1) begin
            n++;
            if (n > ACK_WAIT)
                abort_run($sformatf("no cpu_ack within %0d cycles for address %h",
                                    ACK_WAIT, a));
            @(negedge clk);
        end
        check_word(plain, cpu_dat, $sformatf("%s at %h", op ? "opcode" : "data", a));
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        n_req++;
        model_update(a, op, plain);
    endtask

    task automatic run_opcodes(input int n);
        repeat (n) begin
            access(adr_t'($random(seed)), 1'b1, rand_opcode());
            repeat (rnd(3)) @(negedge clk);  // idle gap
        end
    endtask

    // cmpi.l #imm then command word and end word at consecutive addresses
    task automatic run_cmd(input logic [1:0] cmd, input st_t val, input dat_t end_w);
        adr_t a;
        a = adr_t'($random(seed));
        access(a, 1'b1, 16'h0c80);
        access(adr_t'(a + 1), 1'b0, {6'd0, cmd, val});
        access(adr_t'(a + 2), 1'b0, end_w);
    endtask

    task automatic irq_pulse();
        @(negedge clk);  // clear of the last dec_vld
        irq_ack = 1'b1;
        m_irq   = 1'b1;
        @(negedge clk);
        irq_ack = 1'b0;
    endtask

    task automatic load_keys();
        for (int i = 0; i < 256; i++) begin
            key_we  = 1'b1;
            key_adr = i[KEY_AW-1:0];
            key_dat = key_t'($random(seed));
            key_m[i] = key_dat;
            @(negedge clk);
        end
        key_we = 1'b0;
    endtask

    // rom slave with 0 to 3 wait cycles
    always begin
        @(negedge clk);
        if (rom_stb === 1'b1 && !rom_ack) begin
            repeat (rnd(4)) @(negedge clk);
            if (rom_cyc !== 1'b1 || rom_stb !== 1'b1)
                abort_run("rom_cyc or rom_stb dropped before rom_ack");
            check_adr(rom_exp_adr, rom_adr, "rom_adr of the read");
            rom_dat = rom_plan;
            rom_ack = 1'b1;
            @(negedge clk);
            rom_ack = 1'b0;
            rom_dat = '0;
        end
    end

    always @(negedge clk) begin
        if (cpu_ack === 1'b1)
            ack_cnt++;
        if (cpu_cyc !== 1'b1 && (rom_cyc !== 1'b0 || rom_stb !== 1'b0))
            abort_run("rom port active while the cpu port is idle");
    end

    initial begin
        #(WD_CYCLES * CLK_NS);
        abort_run("watchdog expired, the test did not finish in time");
    end

    initial begin
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        cpu_adr = '0;
        cpu_op  = 1'b0;
        rom_dat = '0;
        rom_ack = 1'b0;
        key_we  = 1'b0;
        key_adr = '0;
        key_dat = '0;
        irq_ack = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        load_keys();

        repeat (N_DATA)  // index from address only
            access(adr_t'($random(seed)), 1'b0, dat_t'($random(seed)));
        run_opcodes(N_OPC);  // state still 0

        run_cmd(CMD_SET, st_t'(rnd(255) + 1), CMD_END);
        run_opcodes(8);

        // irq mode by pulse and rte, then by command
        irq_pulse();
        run_opcodes(8);
        access(adr_t'($random(seed)), 1'b1, OP_RTE);
        run_opcodes(8);
        run_cmd(CMD_IRQ_ON, 8'h00, CMD_END);
        run_opcodes(8);
        run_cmd(CMD_IRQ_OFF, 8'h00, CMD_END);
        run_opcodes(8);

        // reset command from irq mode, then an aborted set
        irq_pulse();
        run_cmd(CMD_RESET, 8'h3c, CMD_END);
        run_opcodes(8);
        run_cmd(CMD_SET, 8'hc3, CMD_END);
        run_cmd(CMD_SET, 8'h18, 16'hfffe);
        run_opcodes(8);

        // random mix with rom delays and cpu gaps
        repeat (N_RAND) begin
            case (rnd(16))
                0: irq_pulse();
                1: run_cmd(2'(rnd(4)), st_t'($random(seed)), rnd(4) == 0 ? 16'h0 : CMD_END);
                2: access(adr_t'($random(seed)), 1'b1, OP_RTE);
                default: access(adr_t'($random(seed)), 1'(rnd(2)), dat_t'($random(seed)));
            endcase
            repeat (rnd(4)) @(negedge clk);
        end

        repeat (8) @(negedge clk);  // catch stray acks
        check_ack_count(n_req, ack_cnt);
        $display("All tests passed!");
        $finish;
    end

endmodule

/* files.f */
verilog/fd1094_pkg.sv
verilog/fd1094_fetch.sv
verilog/fd1094_key_ram.sv
verilog/fd1094_decrypt.sv
verilog/fd1094_ctrl.sv
verilog/fd1094_top.sv
testbench/tb_fd1094.sv
